// File: adc_timing_pkg.sv
// ==============================
// values imposed by the ADC chip itself
// the config layout follows the chip's 12-bit SDI transaction
// ==============================
package adc_timing_pkg;

   // width of the filtered output word read over SDOA
   localparam int adc_word_width = 32;

   // the config transaction is exactly this many SDI bits
   localparam int adc_config_width = 12;

   typedef logic [adc_config_width-1:0] adc_config_t;

   // bits 11:10 are the configuring marker (10), bits 9:8 leave gain expansion
   // and compression off, bits 7:4 select decimation factor 16 and bits 3:0
   // select the flat filter
   localparam adc_config_t config_default = 12'b10_00_0100_0110;

   // capture_clk cycles per conversion, 1 us with a 32 MHz capture_clk
   localparam int default_adc_cycles = 32;

   // cycles that mclk stays high while the conversion completes (687 ns at 32 MHz)
   localparam int default_convert_cycles = 22;

   // bits shifted out of the filter result on each conversion (distributed read)
   localparam int default_read_bits = 2;

endpackage

// File: capture_seq_pkg.sv
// ==============================
// sequencer phase and cycle position types
// cycle_count_t caps adc_cycles at 32
// ==============================
package capture_seq_pkg;

   // phases of the capture sequencer
   // reset and config run once per pipe open, start through wait repeat every
   // conversion period
   typedef enum logic [2:0] {
      st_reset   = 3'd0,
      st_config  = 3'd1,
      st_start   = 3'd2,
      st_convert = 3'd3,
      st_sync    = 3'd4,
      st_acquire = 3'd5,
      st_wait    = 3'd6
   } seq_state_t;

   // position within one conversion period, its LSB also paces scka
   typedef logic [4:0] cycle_count_t;

endpackage

// File: capture_seq_if.sv
// ==============================
// sequencer phase and SPI strobes, all on capture_clk
// plain strobes and levels, no handshake
// ==============================
`timescale 1ns/10ps

interface capture_seq_if import capture_seq_pkg::*; ();

   // registered state of the sequencer
   seq_state_t phase;

   // decoded phase levels, taken straight from the state register
   logic config_active;
   logic read_active;

   // high while the pipe is closed or reset is asserted
   logic run_reset;

   // registered SPI clock and SYNC pulse, the same lines that go to the pins
   logic scka;
   logic sync;

   // level from the config writer once every config bit has been clocked
   logic config_done;

   // one-cycle pulse from the assembler when a full word is in capture_data
   logic word_loaded;

   assign config_active = (phase == st_config);

   // the SYNC slot counts as part of the read window because the MSB is taken
   // on the sync pulse itself
   assign read_active = (phase == st_sync) || (phase == st_acquire);

   modport sequencer (output phase, run_reset, scka, sync,
                      input  config_done, word_loaded);

   modport cfg (input  config_active, scka,
                output config_done);

   modport reader (input  read_active, run_reset, scka, sync,
                   output word_loaded);

endinterface

// File: conversion_sequencer.sv
// ==============================
// adc_cycles must be even and at most 32
// convert plus sync plus 2*read_bits cycles must fit in adc_cycles
// ==============================
`timescale 1ns/10ps

module conversion_sequencer
   import adc_timing_pkg::*;
   import capture_seq_pkg::*;
#(
   parameter int adc_cycles     = default_adc_cycles,
   parameter int convert_cycles = default_convert_cycles,
   parameter int read_bits      = default_read_bits
) (
   input  logic capture_clk,
   input  logic reset,
   input  logic read_open,
   output logic adc_mclk,
   capture_seq_if.sequencer seq
);

   // last counter value of each window in the conversion period
   localparam cycle_count_t convert_last = cycle_count_t'(convert_cycles - 1);
   // the slot right after conversion is reserved for the SYNC pulse
   localparam cycle_count_t sync_last = cycle_count_t'(convert_cycles + 1);
   // each bit needs one full scka period of two cycles
   localparam cycle_count_t acquire_last = cycle_count_t'(convert_cycles + 1 + 2 * read_bits);
   localparam cycle_count_t cycle_last = cycle_count_t'(adc_cycles - 1);

   logic         open_meta;
   logic         run_reset;
   cycle_count_t cycle;
   seq_state_t   state;
   logic         sync_gate;
   logic         scka_q;
   logic         sync_q;
   logic         scka_rise;

   // two-flop synchronizer on the pipe-open level
   // the second stage holds the inverted level with reset folded in, so run_reset
   // is itself a register
   always_ff @(posedge capture_clk) begin
      if (reset) begin
         open_meta <= 1'b0;
         run_reset <= 1'b1;
      end else begin
         open_meta <= read_open;
         run_reset <= !open_meta;
      end
   end

   // free-running position in the conversion period, wrapping at adc_cycles
   always_ff @(posedge capture_clk) begin
      if (reset || run_reset || cycle == cycle_last) begin
         cycle <= '0;
      end else begin
         cycle <= cycle + cycle_count_t'(1);
      end
   end

   // after reset the machine configures the ADC, then parks in wait until the
   // counter wraps so that every conversion starts at cycle zero
   always_ff @(posedge capture_clk) begin
      if (reset || run_reset) begin
         state <= st_reset;
      end else begin
         case (state)
            st_reset: state <= st_config;
            st_config: begin
               if (seq.config_done) begin
                  state <= st_wait;
               end
            end
            st_start: state <= st_convert;
            st_convert: begin
               if (cycle == convert_last) begin
                  state <= st_sync;
               end
            end
            st_sync: begin
               if (cycle == sync_last) begin
                  state <= st_acquire;
               end
            end
            st_acquire: begin
               // with no wait cycles the next conversion starts at once
               if (cycle == acquire_last) begin
                  state <= (cycle == cycle_last) ? st_start : st_wait;
               end
            end
            st_wait: begin
               if (cycle == cycle_last) begin
                  state <= st_start;
               end
            end
            default: state <= st_reset;
         endcase
      end
   end

   // sync_gate remembers that a word was completed, so the next SYNC slot
   // emits a pulse and the first scka of that read is suppressed
   // it is also set on reset so the first word follows a SYNC
   always_ff @(posedge capture_clk) begin
      if (reset || run_reset || seq.word_loaded) begin
         sync_gate <= 1'b1;
      end else if (state == st_acquire) begin
         sync_gate <= 1'b0;
      end
   end

   // scka goes high on odd counter values, so the rise is scheduled from an even one
   assign scka_rise = !cycle[0];

   // the pins are registered to avoid runt pulses, and they lag the state by one cycle
   always_ff @(posedge capture_clk) begin
      if (reset || run_reset) begin
         adc_mclk <= 1'b0;
         scka_q   <= 1'b0;
         sync_q   <= 1'b1;
      end else begin
         adc_mclk <= (state == st_start) || (state == st_convert);
         // the MSB already sits on sdoa after SYNC, so that read skips its first scka
         scka_q <= ((state == st_acquire && !sync_gate) || state == st_config) && scka_rise;
         // the falling SYNC edge restarts the decimation filter and opens the
         // config window
         sync_q <= (state == st_reset) || (state == st_sync && sync_gate && scka_rise);
      end
   end

   assign seq.phase     = state;
   assign seq.run_reset = run_reset;
   assign seq.scka      = scka_q;
   assign seq.sync      = sync_q;

   // SPI traffic during a conversion would add noise to the sample
   mclk_scka_apart: assert property (@(posedge capture_clk) !(adc_mclk && scka_q));

   // every conversion begins right after the counter wraps
   start_at_wrap: assert property (@(posedge capture_clk) disable iff (reset)
      state == st_start |-> cycle == '0);

endmodule

// File: config_writer.sv
// ==============================
// sends the config word MSB first, one bit per scka
// sdi changes on the scka fall, and the ADC samples it on the rise
// ==============================
`timescale 1ns/10ps

module config_writer
   import adc_timing_pkg::*;
#(
   parameter adc_config_t adc_config = config_default
) (
   input  logic capture_clk,
   output logic adc_sdi,
   capture_seq_if.cfg cfg
);

   // one extra scka period after the last bit, so its rising edge clocks the
   // final bit into the ADC before done is reported
   localparam int done_width = adc_config_width + 2;

   adc_config_t           shifter;
   logic [done_width-1:0] done_shift;

   // outside config both registers hold their start values
   always_ff @(posedge capture_clk) begin
      if (!cfg.config_active) begin
         shifter    <= adc_config;
         done_shift <= done_width'(1);
      end else if (cfg.scka) begin
         // scka is high now, so it falls at this edge and the next bit goes out
         shifter    <= {shifter[adc_config_width-2:0], 1'b0};
         done_shift <= {done_shift[done_width-2:0], 1'b0};
      end
   end

   // the one-hot marker reaches the top bit after 13 scka periods
   assign cfg.config_done = done_shift[done_width-1];

   // sdi is idle low except while the ADC is being configured
   always_comb begin
      if (cfg.config_active) begin
         adc_sdi = shifter[adc_config_width-1];
      end else begin
         adc_sdi = 1'b0;
      end
   end

   // the ADC samples sdi on the scka rise, so sdi holds still while scka is high
   sdi_stable_at_sample: assert property (@(posedge capture_clk) cfg.scka |-> $stable(adc_sdi));

endmodule

// File: word_assembler.sv
// ==============================
// builds one word from several conversions
// a word finished while the FIFO is full is dropped
// ==============================
`timescale 1ns/10ps

module word_assembler
   import adc_timing_pkg::*;
   import capture_seq_pkg::*;
(
   input  logic                      capture_clk,
   input  logic                      adc_sdoa,
   input  logic                      capture_full,
   output logic                      capture_en,
   output logic [adc_word_width-1:0] capture_data,
   capture_seq_if.reader rd
);

   // the word position shares the 5-bit range of the cycle counter
   localparam cycle_count_t top_bit = cycle_count_t'(adc_word_width - 1);

   cycle_count_t bit_index;
   logic         take_bit;
   logic         last_bit;
   logic         word_loaded;

   // a bit is taken while scka is high, so at its falling edge
   // sync also acts as a clock here because the MSB is on sdoa before any scka
   assign take_bit = rd.read_active && (rd.scka || rd.sync);

   // new bits enter at the LSB, so the first bit taken ends up as the MSB
   always_ff @(posedge capture_clk) begin
      if (take_bit) begin
         capture_data <= {capture_data[adc_word_width-2:0], adc_sdoa};
      end
   end

   // bit_index counts down across conversions and wraps from 0 back to 31
   // together with the last bit
   always_ff @(posedge capture_clk) begin
      if (rd.run_reset) begin
         bit_index <= top_bit;
         last_bit  <= 1'b0;
      end else if (take_bit) begin
         bit_index <= (bit_index == '0) ? top_bit : bit_index - cycle_count_t'(1);
         last_bit  <= (bit_index == '0);
      end else begin
         last_bit <= 1'b0;
      end
   end

   // the second register delays the strobe until capture_data has been stable
   // for a full cycle
   always_ff @(posedge capture_clk) begin
      if (rd.run_reset) begin
         word_loaded <= 1'b0;
      end else begin
         word_loaded <= last_bit;
      end
   end

   assign rd.word_loaded = word_loaded;

   // nothing is retried, so a word that meets a full FIFO is lost
   assign capture_en = word_loaded && !capture_full && !rd.run_reset;

   // every scka or sync pulse lasts one cycle, so each one yields exactly one bit
   one_bit_per_pulse: assert property (@(posedge capture_clk) disable iff (rd.run_reset)
      take_bit |=> !take_bit);

endmodule

// File: adc_capture_top.sv
// ==============================
// capture controller for an oversampling ADC, fully on capture_clk
// read_open may be asynchronous, all other inputs are synchronous
// ==============================
`timescale 1ns/10ps

module adc_capture_top
   import adc_timing_pkg::*;
#(
   parameter int          adc_cycles     = default_adc_cycles,
   parameter int          convert_cycles = default_convert_cycles,
   parameter int          read_bits      = default_read_bits,
   parameter adc_config_t adc_config     = config_default
) (
   input  logic                      capture_clk,
   input  logic                      reset,
   input  logic                      read_open,
   input  logic                      adc_sdoa,
   input  logic                      capture_full,
   output logic                      adc_mclk,
   output logic                      adc_scka,
   output logic                      adc_sync,
   output logic                      adc_sdi,
   output logic                      capture_en,
   output logic [adc_word_width-1:0] capture_data
);

   // phase and SPI strobes shared by the three blocks
   capture_seq_if u_seq_if ();

   conversion_sequencer #(
      .adc_cycles     (adc_cycles),
      .convert_cycles (convert_cycles),
      .read_bits      (read_bits)
   ) u_sequencer (
      .capture_clk (capture_clk),
      .reset       (reset),
      .read_open   (read_open),
      .adc_mclk    (adc_mclk),
      .seq         (u_seq_if.sequencer)
   );

   // the phase alone decides whether the writer or the assembler owns the SPI lines
   config_writer #(
      .adc_config (adc_config)
   ) u_config_writer (
      .capture_clk (capture_clk),
      .adc_sdi     (adc_sdi),
      .cfg         (u_seq_if.cfg)
   );

   word_assembler u_word_assembler (
      .capture_clk  (capture_clk),
      .adc_sdoa     (adc_sdoa),
      .capture_full (capture_full),
      .capture_en   (capture_en),
      .capture_data (capture_data),
      .rd           (u_seq_if.reader)
   );

   // scka and sync are already registered inside the sequencer
   assign adc_scka = u_seq_if.scka;
   assign adc_sync = u_seq_if.sync;

endmodule

// File: tb_adc_model.sv
// ==============================
// behavioral ADC for the capture testbench
// a SYNC high for two or more cycles means reset and restarts configuration
// ==============================
`timescale 1ns/10ps

module tb_adc_model (
   input  logic capture_clk,
   input  logic scka,
   input  logic sync,
   input  logic sdi,
   output logic sdoa
);

   logic [31:0] words [0:63];
   logic [31:0] head_word;
   logic [31:0] shift_reg;
   logic [11:0] cfg_word;
   int          cfg_count;
   int          wr_ptr;
   int          rd_ptr;
   int          sync_run;
   logic        pending;

   initial begin
      wr_ptr    = 0;
      rd_ptr    = 0;
      head_word = '0;
      shift_reg = '0;
      cfg_word  = '0;
      cfg_count = 0;
      sync_run  = 0;
      pending   = 1'b0;
   end

   // the MSB of the queued word is visible during the SYNC pulse itself
   assign sdoa = (sync && rd_ptr != wr_ptr) ? head_word[31] : shift_reg[31];

   task automatic push_word(input logic [31:0] w);
      words[wr_ptr % 64] = w;
      if (wr_ptr == rd_ptr) begin
         head_word = w;
      end
      wr_ptr = wr_ptr + 1;
   endtask

   // drops whatever is still queued
   task automatic flush_words();
      rd_ptr = wr_ptr;
   endtask

   // all inputs are sampled at the clock edge that ends their high cycle
   always @(posedge capture_clk) begin
      sync_run <= sync ? sync_run + 1 : 0;
      if (sync && sync_run >= 1) begin
         // long SYNC, so the next scka pulses carry a new config word
         cfg_count <= 0;
         pending   <= 1'b0;
         shift_reg <= '0;
      end else if (sync) begin
         pending <= 1'b1;
      end else if (pending) begin
         // a single-cycle SYNC, the MSB was already taken so bit 30 goes next
         pending <= 1'b0;
         if (rd_ptr != wr_ptr) begin
            shift_reg <= head_word << 1;
            rd_ptr = rd_ptr + 1;
            head_word = words[rd_ptr % 64];
         end else begin
            shift_reg <= '0;
         end
      end else if (scka) begin
         if (cfg_count < 12) begin
            cfg_word  <= {cfg_word[10:0], sdi};
            cfg_count <= cfg_count + 1;
         end else begin
            shift_reg <= shift_reg << 1;
         end
      end
   end

endmodule

// File: tb_adc_capture.sv
// ==============================
// directed tests with default parameters
// one word takes 16 conversions, so each waits up to 700 cycles
// ==============================
`timescale 1ns/10ps

module tb_adc_capture import adc_timing_pkg::*; ();

   logic        capture_clk;
   logic        reset;
   logic        read_open;
   logic        capture_full;
   logic        adc_sdoa;
   logic        adc_mclk;
   logic        adc_scka;
   logic        adc_sync;
   logic        adc_sdi;
   logic        capture_en;
   logic [31:0] capture_data;
   logic [31:0] expected [$];
   int          errors;
   int          tests_run;
   int          tests_failed;

   adc_capture_top u_dut (
      .capture_clk (capture_clk), .reset (reset), .read_open (read_open),
      .adc_sdoa (adc_sdoa), .capture_full (capture_full), .adc_mclk (adc_mclk),
      .adc_scka (adc_scka), .adc_sync (adc_sync), .adc_sdi (adc_sdi),
      .capture_en (capture_en), .capture_data (capture_data)
   );

   tb_adc_model u_model (
      .capture_clk (capture_clk), .scka (adc_scka), .sync (adc_sync),
      .sdi (adc_sdi), .sdoa (adc_sdoa)
   );

   initial begin
      capture_clk = 1'b0;
      forever #5 capture_clk = !capture_clk;
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] exp_val,
                              input string msg);
      if (actual !== exp_val) begin
         $display("ERR %0t ns: %s, got %h, expected %h", $time, msg, actual, exp_val);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors != errors_before) begin
         tests_failed++;
      end
      $display("test %s done with %0d errors", name, errors - errors_before);
   endtask

   // outputs are sampled on the falling edge, away from the driving edge
   task automatic wait_config();
      int n;
      n = 0;
      while (u_model.cfg_count != 12 && n < 200) begin
         @(negedge capture_clk);
         n++;
      end
      if (u_model.cfg_count != 12) begin
         $display("timeout: the ADC model never received 12 config bits");
         errors++;
      end
   endtask

   // takes the next capture_en strobe and checks that it lasts one cycle
   task automatic expect_word(input string msg);
      int          n;
      logic [31:0] exp_word;
      n = 0;
      exp_word = expected.pop_front();
      @(negedge capture_clk);
      while (!capture_en && n < 700) begin
         @(negedge capture_clk);
         n++;
      end
      if (!capture_en) begin
         $display("timeout: no capture_en strobe seen for %s", msg);
         errors++;
      end else begin
         check_value(capture_data, exp_word, msg);
         @(negedge capture_clk);
         check_value(capture_en, 1'b0, "capture_en longer than one cycle");
      end
   endtask

   task automatic test_config();
      int e;
      e = errors;
      @(posedge capture_clk);
      read_open <= 1'b1;
      wait_config();
      check_value(u_model.cfg_word, config_default, "config word on sdi");
      finish_test("config", e);
   endtask

   // measures the mclk period and high time over three conversions
   task automatic test_mclk_timing();
      int e;
      int n;
      int high;
      int period;
      e = errors;
      n = 0;
      @(negedge capture_clk);
      while (adc_mclk && n < 100) begin
         @(negedge capture_clk);
         n++;
      end
      n = 0;
      while (!adc_mclk && n < 100) begin
         @(negedge capture_clk);
         n++;
      end
      if (!adc_mclk) begin
         $display("timeout: mclk never started");
         errors++;
      end else begin
         repeat (3) begin
            high = 0;
            period = 0;
            while (adc_mclk && high < 100) begin
               @(negedge capture_clk);
               high++;
            end
            period = high;
            while (!adc_mclk && period < 100) begin
               @(negedge capture_clk);
               period++;
            end
            check_value(high, default_convert_cycles, "mclk high time");
            check_value(period, default_adc_cycles, "mclk period");
         end
      end
      finish_test("mclk_timing", e);
   endtask

   task automatic test_words();
      int e;
      e = errors;
      repeat (4) begin
         expect_word("captured word");
      end
      finish_test("words", e);
   endtask

   // the second word meets a full FIFO and must vanish
   task automatic test_backpressure();
      int e;
      int strobes;
      e = errors;
      strobes = 0;
      expect_word("word before full");
      @(posedge capture_clk);
      capture_full <= 1'b1;
      repeat (520) begin
         @(negedge capture_clk);
         if (capture_en) begin
            strobes++;
         end
      end
      check_value(strobes, 0, "capture_en strobes while full");
      // the word that met the full FIFO leaves the expected order
      void'(expected.pop_front());
      @(posedge capture_clk);
      capture_full <= 1'b0;
      expect_word("word after full");
      finish_test("backpressure", e);
   endtask

   task automatic test_reopen();
      int          e;
      logic [31:0] w;
      e = errors;
      @(posedge capture_clk);
      read_open <= 1'b0;
      // two synchronizer flops and one output register
      repeat (5) @(negedge capture_clk);
      repeat (8) begin
         @(negedge capture_clk);
         check_value(adc_mclk, 1'b0, "mclk while closed");
         check_value(adc_scka, 1'b0, "scka while closed");
         check_value(adc_sdi, 1'b0, "sdi while closed");
         check_value(capture_en, 1'b0, "capture_en while closed");
         check_value(adc_sync, 1'b1, "sync while closed");
      end
      check_value(u_model.cfg_count, 0, "config restart in the ADC model");
      u_model.flush_words();
      expected.delete();
      repeat (2) begin
         w = $urandom();
         u_model.push_word(w);
         expected.push_back(w);
      end
      @(posedge capture_clk);
      read_open <= 1'b1;
      wait_config();
      check_value(u_model.cfg_word, config_default, "config word after reopen");
      expect_word("first word after reopen");
      expect_word("second word after reopen");
      finish_test("reopen", e);
   endtask

   initial begin
      logic [31:0] w;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      void'($urandom(32'h3f3c8427));
      reset = 1'b1;
      read_open = 1'b0;
      capture_full = 1'b0;
      repeat (10) @(posedge capture_clk);
      reset <= 1'b0;
      // the words for the data tests are queued before the first SYNC
      repeat (7) begin
         w = $urandom();
         u_model.push_word(w);
         expected.push_back(w);
      end
      test_config();
      test_mclk_timing();
      test_words();
      test_backpressure();
      test_reopen();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: adc_capture.f
adc_timing_pkg.sv
capture_seq_pkg.sv
capture_seq_if.sv
conversion_sequencer.sv
config_writer.sv
word_assembler.sv
adc_capture_top.sv
tb_adc_model.sv
tb_adc_capture.sv
